/* bench/mipsPipelineChecker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-back checker
// compares register write-back beats and fin against a
// queue of expected writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mipsPipelineChecker import mipsIsaPkg::*; (
    input logic                    clk,
    input logic                    rst,
    input logic                    wbValid,
    input logic [regAddrWidth-1:0] wbAddr,
    input logic [wordWidth-1:0]    wbData,
    input logic                    fin
);

    logic [regAddrWidth-1:0] expAddrQ [$];
    logic [wordWidth-1:0]    expDataQ [$];
    logic [regAddrWidth-1:0] expAddr;
    logic [wordWidth-1:0]    expData;
    logic                    rstPrev = 1'b0;
    logic                    finPrev = 1'b0;
    int                      mismatchCount = 0;
    int                      unexpectedCount = 0;
    int                      missingCount = 0;
    int                      finErrorCount = 0;

    task automatic expectWrite(input logic [regAddrWidth-1:0] addr,
                               input logic [wordWidth-1:0] data);
        expAddrQ.push_back(addr);
        expDataQ.push_back(data);
    endtask

    always @(posedge clk) begin
        rstPrev <= rst;
        finPrev <= fin && !rst;
        if (!rst) begin
            // first cycle out of reset
            if (rstPrev && fin !== 1'b0) begin
                $display("fin is not low after reset");
                finErrorCount++;
            end
            if (wbValid) begin
                if (expAddrQ.size() == 0) begin
                    $display("unexpected write of %h to register %0d", wbData, wbAddr);
                    unexpectedCount++;
                end else begin
                    expAddr = expAddrQ.pop_front();
                    expData = expDataQ.pop_front();
                    if (wbAddr !== expAddr) begin
                        $display("mismatch wbAddr: expected %h, got %h", expAddr, wbAddr);
                        mismatchCount++;
                    end
                    if (wbData !== expData) begin
                        $display("mismatch wbData: expected %h, got %h", expData, wbData);
                        mismatchCount++;
                    end
                end
            end
            // halt reached write-back, nothing may be left
            if (fin === 1'b1 && !finPrev && expAddrQ.size() != 0) begin
                $display("fin rose with %0d expected writes still missing", expAddrQ.size());
                missingCount += expAddrQ.size();
                expAddrQ.delete();
                expDataQ.delete();
            end
        end
    end

endmodule

/* bench/mipsPipelineTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline testbench
// loads each program from the cases file, resets the core,
// waits for fin and reports the checker's error counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mipsPipelineTb import mipsIsaPkg::*; import mipsPipePkg::*; ();

    localparam int caseMemDepth = 256;

    logic                     clk;
    logic                     rst;
    logic                     imemWe;
    logic [imemAddrWidth-1:0] imemAddr;
    logic [wordWidth-1:0]     imemData;
    logic                     wbValid;
    logic [regAddrWidth-1:0]  wbAddr;
    logic [wordWidth-1:0]     wbData;
    logic                     fin;

    logic [wordWidth-1:0] caseMem [caseMemDepth];
    int                   cycleLimit;
    int                   cycleCount;
    int                   casePos;
    int                   caseCount;
    int                   errorTotal;

    mipsPipeline dut_i (
        .clk(clk), .rst(rst),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData), .fin(fin)
    );

    mipsPipelineChecker checker_i (
        .clk(clk), .rst(rst),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData), .fin(fin)
    );

    always #4 clk = ~clk;

    // start of the case after the one at base
    function automatic int nextCase(input int base);
        int wordCount;
        wordCount = caseMem[base];
        return base + 2 + wordCount + 2 * caseMem[base + 1 + wordCount];
    endfunction

    task automatic loadProgram(input int base, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            #1;
            imemWe   = 1'b1;
            imemAddr = imemAddrWidth'(i);
            imemData = caseMem[base + i];
        end
        @(posedge clk);
        #1;
        imemWe = 1'b0;
    endtask

    task automatic queueWrites(input int base, input int count);
        for (int i = 0; i < count; i++)
            checker_i.expectWrite(caseMem[base + 2 * i][regAddrWidth-1:0],
                                  caseMem[base + 2 * i + 1]);
    endtask

    // program loads while the previous one sits halted, then a 3-cycle reset
    task automatic runCase(input int base);
        int wordCount;
        int writeCount;
        wordCount  = caseMem[base];
        writeCount = caseMem[base + 1 + wordCount];
        loadProgram(base + 1, wordCount);
        queueWrites(base + 2 + wordCount, writeCount);
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (fin !== 1'b1);
        // idle gap before the next case
        repeat ($urandom % 4) @(posedge clk);
    endtask

    task automatic printCounts();
        $display("errors: %0d mismatches, %0d unexpected, %0d missing, %0d fin, %0d assertions",
                 checker_i.mismatchCount, checker_i.unexpectedCount,
                 checker_i.missingCount, checker_i.finErrorCount,
                 dut_i.assert_i.failCount);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        imemWe    = 1'b0;
        imemAddr  = '0;
        imemData  = '0;
        void'($urandom(28));
        $readmemh("bench/mipsPipeline_cases.txt", caseMem);
        // four cycles per program word plus slack for reset and drain
        casePos    = 0;
        caseCount  = 0;
        cycleLimit = 0;
        while (caseMem[casePos] != '0) begin
            cycleLimit += 4 * caseMem[casePos] + 20;
            caseCount++;
            casePos = nextCase(casePos);
        end
        casePos = 0;
        for (int c = 0; c < caseCount; c++) begin
            runCase(casePos);
            casePos = nextCase(casePos);
        end
        if (caseCount == 0)
            $display("no cases found in the cases file");
        errorTotal = checker_i.mismatchCount + checker_i.unexpectedCount
                   + checker_i.missingCount + checker_i.finErrorCount
                   + dut_i.assert_i.failCount;
        printCounts();
        if (errorTotal == 0 && caseCount != 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        cycleCount = 0;
        @(posedge clk);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: fin was not reached within %0d cycles", cycleLimit);
        printCounts();
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* bench/mipsPipeline_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound assertions on the pipeline outputs
// reset of fin, write-back address and fin stickiness
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mipsPipelineAssert import mipsIsaPkg::*; (
    input logic                    clk,
    input logic                    rst,
    input logic                    wbValid,
    input logic [regAddrWidth-1:0] wbAddr,
    input logic                    fin
);

    logic resetDone = 1'b0;
    int   failCount = 0;

    always @(posedge clk) begin
        if (rst)
            resetDone <= 1'b1;
    end

    finClear: assert property (@(posedge clk) rst |=> !fin)
        else begin
            $error("fin high in the cycle after reset");
            failCount++;
        end

    wbAddrNonZero: assert property (@(posedge clk) wbValid |-> wbAddr != '0)
        else begin
            $error("write-back to register zero");
            failCount++;
        end

    finSticky: assert property (@(posedge clk) (fin && !rst) |=> fin)
        else begin
            $error("fin dropped without reset");
            failCount++;
        end

    wbValidKnown: assert property (@(posedge clk) resetDone |-> !$isunknown(wbValid))
        else begin
            $error("wbValid unknown after reset");
            failCount++;
        end

endmodule

bind mipsPipeline mipsPipelineAssert assert_i (
    .clk(clk), .rst(rst), .wbValid(wbValid), .wbAddr(wbAddr), .fin(fin)
);

/* bench/mipsPipeline_cases.txt */
// per case: word count, program words, write count, then register and value pairs
// all numbers in hex, a zero word count ends the list
// alu operations in program order
8
20010005 2002FFFD 00221820 00222022 00222824 00223025 0041382A FC000000
7
01 00000005 02 FFFFFFFD 03 00000002 04 00000008 05 00000005 06 FFFFFFFD 07 00000001
// forwarding chain, store then load, load-use stall
7
20080010 21090007 01285020 AD0A0004 8D0B0004 01696022 FC000000
5
08 00000010 09 00000017 0A 00000027 0B 00000027 0C 00000010
// taken beq, not-taken beq, jump
0E
20010001 20020001 10220003 20030033 20040044 20050055 10200003
200D0013 0800000C 200E0014 200F0015 20100016 21B10001 FC000000
4
01 00000001 02 00000001 0D 00000013 11 00000014
0

/* logic/decodeStage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage
// control decode, register file, sign extension,
// load-use hazard detection and the ID/EX register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module decodeStage import mipsIsaPkg::*; import mipsPipePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [instrWidth-1:0]   instruction,
    input  logic [wordWidth-1:0]    pcNext,
    input  logic                    ifValid,
    input  logic                    redirect,
    fwdIf.dec                       wb,
    output logic                    stall,
    output logic                    haltSeen,
    output ctrlT                    idCtrl,
    output logic [wordWidth-1:0]    rsVal,
    output logic [wordWidth-1:0]    rtVal,
    output logic [wordWidth-1:0]    immExt,
    output logic [wordWidth-1:0]    idPcNext,
    output logic [regAddrWidth-1:0] rs,
    output logic [regAddrWidth-1:0] rt,
    output logic [regAddrWidth-1:0] dst
);

    logic [wordWidth-1:0]    regFile [2**regAddrWidth];
    logic [opWidth-1:0]      opcode;
    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [regAddrWidth-1:0] rdAddr;
    ctrlT                    ctrl;

    // r0 reads as zero, same-cycle write-back bypasses the array
    function automatic logic [wordWidth-1:0] readReg(input logic [regAddrWidth-1:0] addr);
        if (addr == '0)
            return '0;
        if (wb.wbRegWr && wb.wbDst == addr)
            return wb.wbData;
        return regFile[addr];
    endfunction

    assign opcode = instruction[opLsb +: opWidth];
    assign rsAddr = instruction[rsLsb +: regAddrWidth];
    assign rtAddr = instruction[rtLsb +: regAddrWidth];
    assign rdAddr = instruction[rdLsb +: regAddrWidth];

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = aluAdd;
        case (opcode)
            opRtype: begin
                ctrl.regWr    = 1'b1;
                ctrl.regDstRd = 1'b1;
            end
            opAddi: begin
                ctrl.regWr     = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opLw: begin
                ctrl.regWr     = 1'b1;
                ctrl.memRd     = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opSw: begin
                ctrl.memWr     = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
            end
            opJ:    ctrl.jump = 1'b1;
            opHalt: ctrl.halt = 1'b1;
            default: ;
        endcase
    end

    // load in execute feeding this instruction
    assign stall    = idCtrl.memRd && (rt == rsAddr || rt == rtAddr);
    assign haltSeen = ifValid && opcode == opHalt;

    always_ff @(posedge clk) begin
        if (wb.wbRegWr && wb.wbDst != '0)
            regFile[wb.wbDst] <= wb.wbData;
    end

    always_ff @(posedge clk) begin
        if (rst)
            idCtrl <= '0;
        else if (stall || redirect || !ifValid)
            idCtrl <= '0;
        else
            idCtrl <= ctrl;
    end

    always_ff @(posedge clk) begin
        rsVal    <= readReg(rsAddr);
        rtVal    <= readReg(rtAddr);
        immExt   <= {{(wordWidth-immWidth){instruction[immWidth-1]}},
                     instruction[immWidth-1:0]};
        idPcNext <= pcNext;
        rs       <= rsAddr;
        rt       <= rtAddr;
        dst      <= ctrl.regDstRd ? rdAddr : rtAddr;
    end

endmodule

/* logic/executeStage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage
// operand forwarding, ALU, branch and jump targets, EX/MEM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module executeStage import mipsIsaPkg::*; import mipsPipePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  ctrlT                    idCtrl,
    input  logic [wordWidth-1:0]    rsVal,
    input  logic [wordWidth-1:0]    rtVal,
    input  logic [wordWidth-1:0]    immExt,
    input  logic [wordWidth-1:0]    idPcNext,
    input  logic [regAddrWidth-1:0] rs,
    input  logic [regAddrWidth-1:0] rt,
    input  logic [regAddrWidth-1:0] dst,
    input  logic                    redirect,
    fwdIf.exec                      fwd,
    output ctrlT                    exCtrl,
    output logic [wordWidth-1:0]    aluResult,
    output logic [wordWidth-1:0]    storeData,
    output logic [wordWidth-1:0]    branchTarget,
    output logic [wordWidth-1:0]    jumpTarget,
    output logic                    zero,
    output logic [regAddrWidth-1:0] exDst
);

    fwdSelT               selA;
    fwdSelT               selB;
    logic [wordWidth-1:0] opA;
    logic [wordWidth-1:0] fwdRt;
    logic [wordWidth-1:0] opB;
    logic [wordWidth-1:0] aluOut;
    aluOpT                aluOpSel;

    // nearest producer wins
    function automatic fwdSelT pickSrc(input logic [regAddrWidth-1:0] src);
        if (fwd.memRegWr && fwd.memDst != '0 && fwd.memDst == src)
            return fwdExMem;
        if (fwd.wbRegWr && fwd.wbDst != '0 && fwd.wbDst == src)
            return fwdMemWb;
        return fwdReg;
    endfunction

    function automatic logic [wordWidth-1:0] applySrc(input fwdSelT sel,
                                                      input logic [wordWidth-1:0] regVal);
        case (sel)
            fwdExMem: return fwd.memResult;
            fwdMemWb: return fwd.wbData;
            default:  return regVal;
        endcase
    endfunction

    assign selA  = pickSrc(rs);
    assign selB  = pickSrc(rt);
    assign opA   = applySrc(selA, rsVal);
    assign fwdRt = applySrc(selB, rtVal);
    assign opB   = idCtrl.aluSrcImm ? immExt : fwdRt;

    // R-type takes its operation from funct
    always_comb begin
        aluOpSel = idCtrl.aluOp;
        if (idCtrl.regDstRd) begin
            case (immExt[functWidth-1:0])
                fnAdd:   aluOpSel = aluAdd;
                fnSub:   aluOpSel = aluSub;
                fnAnd:   aluOpSel = aluAnd;
                fnOr:    aluOpSel = aluOr;
                fnSlt:   aluOpSel = aluSlt;
                default: aluOpSel = aluAdd;
            endcase
        end
    end

    always_comb begin
        case (aluOpSel)
            aluSub:  aluOut = opA - opB;
            aluAnd:  aluOut = opA & opB;
            aluOr:   aluOut = opA | opB;
            aluSlt:  aluOut = wordWidth'($signed(opA) < $signed(opB));
            default: aluOut = opA + opB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || redirect)
            exCtrl <= '0;
        else
            exCtrl <= idCtrl;
    end

    always_ff @(posedge clk) begin
        aluResult    <= aluOut;
        storeData    <= fwdRt;
        zero         <= aluOut == '0;
        branchTarget <= idPcNext + (immExt << byteOffsetWidth);
        // 26-bit target rebuilt from the rs, rt and immediate fields
        jumpTarget   <= {idPcNext[wordWidth-1:wordWidth-4], rs, rt,
                         immExt[immWidth-1:0], 2'b00};
        exDst        <= dst;
    end

endmodule

/* logic/fetchStage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch stage
// PC, loadable instruction memory and the IF/ID register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fetchStage import mipsIsaPkg::*; import mipsPipePkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     imemWe,
    input  logic [imemAddrWidth-1:0] imemAddr,
    input  logic [wordWidth-1:0]     imemData,
    input  logic                     stall,
    input  logic                     haltSeen,
    input  logic                     redirect,
    input  logic [wordWidth-1:0]     redirectTarget,
    output logic [instrWidth-1:0]    instruction,
    output logic [wordWidth-1:0]     pcNext,
    output logic                     ifValid
);

    logic [wordWidth-1:0]  pc;
    logic [instrWidth-1:0] imem [imemDepth];
    logic                  hold;

    assign hold = stall || haltSeen;

    // program load port
    always_ff @(posedge clk) begin
        if (imemWe)
            imem[imemAddr] <= imemData;
    end

    // redirect wins over stall and halt
    always_ff @(posedge clk) begin
        if (rst)
            pc <= '0;
        else if (redirect)
            pc <= redirectTarget;
        else if (!hold)
            pc <= pc + wordWidth'(4);
    end

    always_ff @(posedge clk) begin
        if (rst || redirect)
            ifValid <= 1'b0;
        else if (!hold)
            ifValid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            instruction <= imem[pc[imemAddrWidth+byteOffsetWidth-1:byteOffsetWidth]];
            pcNext      <= pc + wordWidth'(4);
        end
    end

endmodule

/* logic/fwdIf.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// forwarding bus
// EX/MEM and MEM/WB results fed back to execute and decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface fwdIf import mipsIsaPkg::*; ();
    // EX/MEM side
    logic                    memRegWr;
    logic [regAddrWidth-1:0] memDst;
    logic [wordWidth-1:0]    memResult;
    // MEM/WB side, also the register file write port
    logic                    wbRegWr;
    logic [regAddrWidth-1:0] wbDst;
    logic [wordWidth-1:0]    wbData;

    modport exec (input memRegWr, memDst, memResult, wbRegWr, wbDst, wbData);
    modport dec (input wbRegWr, wbDst, wbData);
endinterface

/* logic/memoryStage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory stage
// data memory, branch and jump redirect, MEM/WB and fin
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module memoryStage import mipsIsaPkg::*; import mipsPipePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  ctrlT                    exCtrl,
    input  logic [wordWidth-1:0]    aluResult,
    input  logic [wordWidth-1:0]    storeData,
    input  logic [wordWidth-1:0]    branchTarget,
    input  logic [wordWidth-1:0]    jumpTarget,
    input  logic                    zero,
    input  logic [regAddrWidth-1:0] exDst,
    fwdIf                           fwd,
    output logic                    redirect,
    output logic [wordWidth-1:0]    redirectTarget,
    output logic                    wbValid,
    output logic [regAddrWidth-1:0] wbAddr,
    output logic [wordWidth-1:0]    wbData,
    output logic                    fin
);

    logic [wordWidth-1:0]     dmem [dmemDepth];
    logic [dmemAddrWidth-1:0] dmemIdx;
    logic [wordWidth-1:0]     memRdData;

    // word index taken above the byte offset
    assign dmemIdx   = aluResult[dmemAddrWidth+byteOffsetWidth-1:byteOffsetWidth];
    assign memRdData = dmem[dmemIdx];

    always_ff @(posedge clk) begin
        if (exCtrl.memWr)
            dmem[dmemIdx] <= storeData;
    end

    assign redirect       = exCtrl.jump || (exCtrl.branch && zero);
    assign redirectTarget = exCtrl.jump ? jumpTarget : branchTarget;

    // forwarding sources for the younger stages
    assign fwd.memRegWr  = exCtrl.regWr;
    assign fwd.memDst    = exDst;
    assign fwd.memResult = aluResult;
    assign fwd.wbRegWr   = wbValid;
    assign fwd.wbDst     = wbAddr;
    assign fwd.wbData    = wbData;

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
            fin     <= 1'b0;
        end else begin
            wbValid <= exCtrl.regWr && exDst != '0;
            // sticky until reset
            if (exCtrl.halt)
                fin <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        wbAddr <= exDst;
        wbData <= exCtrl.memToReg ? memRdData : aluResult;
    end

endmodule

/* logic/mipsIsaPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS instruction set definitions
// opcodes, funct codes, field positions and the ALU operations
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mipsIsaPkg;

    localparam int instrWidth   = 32;
    localparam int wordWidth    = 32;
    localparam int regAddrWidth = 5;

    // instruction fields
    localparam int opWidth    = 6;
    localparam int functWidth = 6;
    localparam int immWidth   = 16;
    localparam int opLsb      = 26;
    localparam int rsLsb      = 21;
    localparam int rtLsb      = 16;
    localparam int rdLsb      = 11;

    localparam logic [opWidth-1:0] opRtype = 6'h00;
    localparam logic [opWidth-1:0] opJ     = 6'h02;
    localparam logic [opWidth-1:0] opBeq   = 6'h04;
    localparam logic [opWidth-1:0] opAddi  = 6'h08;
    localparam logic [opWidth-1:0] opLw    = 6'h23;
    localparam logic [opWidth-1:0] opSw    = 6'h2b;
    // halt stops fetch and raises fin
    localparam logic [opWidth-1:0] opHalt  = 6'h3f;

    localparam logic [functWidth-1:0] fnAdd = 6'h20;
    localparam logic [functWidth-1:0] fnSub = 6'h22;
    localparam logic [functWidth-1:0] fnAnd = 6'h24;
    localparam logic [functWidth-1:0] fnOr  = 6'h25;
    localparam logic [functWidth-1:0] fnSlt = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

endpackage

/* logic/mipsPipePkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline definitions
// memory sizes, control bundle and forwarding selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mipsPipePkg;
    import mipsIsaPkg::*;

    localparam int imemDepth       = 256;
    localparam int dmemDepth       = 256;
    localparam int imemAddrWidth   = $clog2(imemDepth);
    localparam int dmemAddrWidth   = $clog2(dmemDepth);
    // byte address bits below the word index
    localparam int byteOffsetWidth = 2;

    // control bundle carried from decode down to write-back
    typedef struct packed {
        logic  regWr;
        logic  memRd;
        logic  memWr;
        logic  memToReg;
        logic  aluSrcImm;
        logic  regDstRd;
        logic  branch;
        logic  jump;
        logic  halt;
        aluOpT aluOp;
    } ctrlT;

    typedef enum logic [1:0] {
        fwdReg,
        fwdExMem,
        fwdMemWb
    } fwdSelT;

endpackage

/* logic/mipsPipeline.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// five-stage pipelined MIPS core
// wires fetch, decode, execute and memory with the fwd bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mipsPipeline import mipsIsaPkg::*; import mipsPipePkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     imemWe,
    input  logic [imemAddrWidth-1:0] imemAddr,
    input  logic [wordWidth-1:0]     imemData,
    output logic                     wbValid,
    output logic [regAddrWidth-1:0]  wbAddr,
    output logic [wordWidth-1:0]     wbData,
    output logic                     fin
);

    logic [instrWidth-1:0]   instruction;
    logic [wordWidth-1:0]    pcNext;
    logic                    ifValid;
    logic                    stall;
    logic                    haltSeen;
    ctrlT                    idCtrl;
    logic [wordWidth-1:0]    rsVal;
    logic [wordWidth-1:0]    rtVal;
    logic [wordWidth-1:0]    immExt;
    logic [wordWidth-1:0]    idPcNext;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] dst;
    ctrlT                    exCtrl;
    logic [wordWidth-1:0]    aluResult;
    logic [wordWidth-1:0]    storeData;
    logic [wordWidth-1:0]    branchTarget;
    logic [wordWidth-1:0]    jumpTarget;
    logic                    zero;
    logic [regAddrWidth-1:0] exDst;
    logic                    redirect;
    logic [wordWidth-1:0]    redirectTarget;

    fwdIf fwdBus ();

    fetchStage fetch_i (
        .clk(clk), .rst(rst),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .stall(stall), .haltSeen(haltSeen),
        .redirect(redirect), .redirectTarget(redirectTarget),
        .instruction(instruction), .pcNext(pcNext), .ifValid(ifValid)
    );

    decodeStage decode_i (
        .clk(clk), .rst(rst),
        .instruction(instruction), .pcNext(pcNext), .ifValid(ifValid),
        .redirect(redirect), .wb(fwdBus),
        .stall(stall), .haltSeen(haltSeen), .idCtrl(idCtrl),
        .rsVal(rsVal), .rtVal(rtVal), .immExt(immExt), .idPcNext(idPcNext),
        .rs(rs), .rt(rt), .dst(dst)
    );

    executeStage execute_i (
        .clk(clk), .rst(rst),
        .idCtrl(idCtrl), .rsVal(rsVal), .rtVal(rtVal), .immExt(immExt),
        .idPcNext(idPcNext), .rs(rs), .rt(rt), .dst(dst),
        .redirect(redirect), .fwd(fwdBus),
        .exCtrl(exCtrl), .aluResult(aluResult), .storeData(storeData),
        .branchTarget(branchTarget), .jumpTarget(jumpTarget),
        .zero(zero), .exDst(exDst)
    );

    memoryStage memory_i (
        .clk(clk), .rst(rst),
        .exCtrl(exCtrl), .aluResult(aluResult), .storeData(storeData),
        .branchTarget(branchTarget), .jumpTarget(jumpTarget),
        .zero(zero), .exDst(exDst), .fwd(fwdBus),
        .redirect(redirect), .redirectTarget(redirectTarget),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData), .fin(fin)
    );

endmodule

/* mipsPipeline.f */
logic/mipsIsaPkg.sv
logic/mipsPipePkg.sv
logic/fwdIf.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/mipsPipeline.sv
bench/mipsPipelineChecker.sv
bench/mipsPipeline_assert.sv
bench/mipsPipelineTb.sv
